// ==== design/mul_ctrl.sv ====
`timescale 1ns/1ps

module mul_ctrl
(
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    output logic in_ready,
    output logic out_valid,
    input  logic out_ready,
    input  logic last_step,
    output logic load,
    output logic step,
    output logic clear
);
    import mul_pkg::*;

    mul_state_t state;
    mul_state_t state_nxt;

    // handshake outputs decoded from state only
    assign in_ready  = (state == ST_IDLE);
    assign out_valid = (state == ST_DONE);

    assign load  = in_valid && in_ready; // accept condition
    assign clear = load;                 // restart step count with each load
    assign step  = (state == ST_RUN);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (load)
                begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN:
            begin
                if (step && last_step)
                begin
                    state_nxt = ST_DONE; // final shift-add lands this edge
                end
            end
            ST_DONE:
            begin
                if (out_ready)
                begin
                    state_nxt = ST_IDLE; // result taken
                end
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

endmodule

// ==== design/mul_pkg.sv ====
package mul_pkg;

    // operand width used when the top level is not overridden
    localparam int mul_width_default = 32;

    // one multiply request as it arrives from the core
    typedef struct packed
    {
        logic [mul_width_default-1:0] op1;       // multiplicand
        logic [mul_width_default-1:0] op2;       // multiplier
        logic                         is_signed; // 1 for MULT, 0 for MULTU
    } mul_req_t;

    // full double-width result, hi and lo words together
    typedef struct packed
    {
        logic [2*mul_width_default-1:0] product;
    } mul_rsp_t;

    // controller states
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0, // waiting for a request
        ST_RUN  = 2'd1, // shift-add steps in progress
        ST_DONE = 2'd2  // result offered on the output
    } mul_state_t;

endpackage

// ==== design/mul_shift_add.sv ====
`timescale 1ns/1ps

module mul_shift_add
#(
    parameter int WIDTH = 32
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              load,
    input  logic              step,
    input  mul_pkg::mul_req_t in_req,
    output mul_pkg::mul_rsp_t out_rsp
);
    logic [WIDTH-1:0]   op1;
    logic [WIDTH-1:0]   op2;
    logic               op1_neg;
    logic               op2_neg;
    logic [WIDTH-1:0]   op1_abs;
    logic [WIDTH-1:0]   op2_abs;

    logic [2*WIDTH-1:0] multiplicand;
    logic [WIDTH-1:0]   multiplier;
    logic [2*WIDTH-1:0] acc;
    logic               res_neg;
    logic [2*WIDTH-1:0] partial;
    logic [2*WIDTH-1:0] result;

    assign op1 = in_req.op1[WIDTH-1:0];
    assign op2 = in_req.op2[WIDTH-1:0];

    // sign bits only matter for MULT
    assign op1_neg = in_req.is_signed && op1[WIDTH-1];
    assign op2_neg = in_req.is_signed && op2[WIDTH-1];

    // most negative value maps to 2**(WIDTH-1), still exact unsigned
    assign op1_abs = op1_neg ? (~op1 + 1'b1) : op1;
    assign op2_abs = op2_neg ? (~op2 + 1'b1) : op2;

    // shifted multiplicand joins the sum when the multiplier lsb is set
    assign partial = multiplier[0] ? multiplicand : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            multiplicand <= '0;
            multiplier   <= '0;
            acc          <= '0;
            res_neg      <= 1'b0;
        end
        else if (load)
        begin
            multiplicand <= {{WIDTH{1'b0}}, op1_abs};
            multiplier   <= op2_abs;
            acc          <= '0;
            res_neg      <= op1_neg ^ op2_neg; // negative only if signs differ
        end
        else if (step)
        begin
            acc          <= acc + partial;
            multiplicand <= {multiplicand[2*WIDTH-2:0], 1'b0};
            multiplier   <= {1'b0, multiplier[WIDTH-1:1]};
        end
    end

    // two's complement of the magnitude for a negative product
    assign result = res_neg ? (~acc + 1'b1) : acc;

    assign out_rsp.product = result;

endmodule

// ==== design/mul_step_counter.sv ====
`timescale 1ns/1ps

module mul_step_counter
#(
    parameter int WIDTH = 32
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic clear,
    input  logic step,
    output logic last_step
);
    // holds 0 .. WIDTH-1, enough for one step per operand bit
    localparam int CNT_W = (WIDTH > 2) ? $clog2(WIDTH) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WIDTH - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            count <= '0;
        end
        else if (step)
        begin
            count <= count + 1'b1; // wraps after the last step, clear reloads it
        end
    end

    // high during the cycle whose edge performs the final step
    assign last_step = (count == LAST);

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit
#(
    parameter int WIDTH = mul_pkg::mul_width_default
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  mul_pkg::mul_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output mul_pkg::mul_rsp_t out_rsp
);
    logic load;      // operands captured this edge
    logic step;      // one shift-add per edge
    logic clear;     // counter restart
    logic last_step; // final step of the product

    mul_ctrl ctrl_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .last_step (last_step),
        .load      (load),
        .step      (step),
        .clear     (clear)
    );

    mul_step_counter
    #(
        .WIDTH (WIDTH)
    )
    cnt_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .step      (step),
        .last_step (last_step)
    );

    mul_shift_add
    #(
        .WIDTH (WIDTH)
    )
    dp_i
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load),
        .step    (step),
        .in_req  (in_req),
        .out_rsp (out_rsp)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_mul_unit -f vlog.f

status=0
./obj_dir/Vtb_mul_unit > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi
echo "simulation passed"

// ==== tb/mul_unit_asserts.sv ====
`timescale 1ns/1ps

module mul_unit_asserts
#(
    parameter int WIDTH = 32
)
(
    input logic                clk,
    input logic                arst_n,
    input logic                in_valid,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input mul_pkg::mul_rsp_t   out_rsp,
    input mul_pkg::mul_state_t state
);
    import mul_pkg::*;

    // result frozen while the sink holds off
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_rsp)))
        else $error("out_valid or out_rsp changed during back-pressure");

    // one operation in flight
    no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    // sampled values lag one edge, hence WIDTH then WIDTH+1
    fixed_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && in_ready) |-> ##WIDTH !out_valid ##1 out_valid)
        else $error("out_valid did not rise exactly WIDTH cycles after accept");

    // datapath moves only on load and step edges
    quiet_outside_run: assert property (@(posedge clk) disable iff (!arst_n)
        (state != ST_RUN && !(in_valid && in_ready)) |=> $stable(out_rsp))
        else $error("out_rsp changed outside a load or step edge");

endmodule

bind mul_unit mul_unit_asserts
#(
    .WIDTH (WIDTH)
)
asserts_i
(
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp),
    .state     (ctrl_i.state)
);

// ==== tb/tb_mul_unit.sv ====
`timescale 1ns/1ps

module tb_mul_unit;
    import mul_pkg::*;

    localparam int WIDTH           = mul_width_default;
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TABLE       = 12;
    localparam int NUM_RANDOM      = 20;
    localparam int MAX_STALL       = 5;
    localparam int NUM_ROWS        = NUM_TABLE + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_ROWS * (WIDTH + 2 + MAX_STALL) + 50);

    typedef struct packed
    {
        mul_req_t           req;
        logic [3:0]         stall;    // cycles with out_ready low
        logic [2*WIDTH-1:0] expected;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    mul_req_t in_req;
    logic     out_valid;
    logic     out_ready;
    mul_rsp_t out_rsp;

    row_t rows[$];
    int   errors = 0;

    mul_unit
    #(
        .WIDTH (WIDTH)
    )
    dut_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // extend both operands to full width, low half of the product is exact
    function automatic logic [2*WIDTH-1:0] ref_product(input mul_req_t r);
        logic [2*WIDTH-1:0] a;
        logic [2*WIDTH-1:0] b;
        a = {{WIDTH{r.is_signed & r.op1[WIDTH-1]}}, r.op1};
        b = {{WIDTH{r.is_signed & r.op2[WIDTH-1]}}, r.op2};
        return a * b;
    endfunction

    function automatic row_t make_row(input logic [WIDTH-1:0] op1, input logic [WIDTH-1:0] op2,
                                      input logic is_signed, input logic [3:0] stall,
                                      input logic [2*WIDTH-1:0] expected);
        row_t r;
        r.req.op1       = op1;
        r.req.op2       = op2;
        r.req.is_signed = is_signed;
        r.stall         = stall;
        r.expected      = expected;
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [2*WIDTH-1:0] expected,
                                   input logic [2*WIDTH-1:0] actual);
        errors++;
        $display("Fail at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic build_rows();
        logic [31:0] seed;
        row_t        r;
        // hand-worked products, same pairs reused unsigned in the last rows
        rows.push_back(make_row(32'd3,          32'd5,          1'b1, 4'd0, 64'h0000_0000_0000_000f));
        rows.push_back(make_row(32'hffff_fffd, 32'd5,          1'b1, 4'd1, 64'hffff_ffff_ffff_fff1));
        rows.push_back(make_row(32'd7,          32'hffff_fffa, 1'b1, 4'd2, 64'hffff_ffff_ffff_ffd6));
        rows.push_back(make_row(32'hffff_fff9, 32'hffff_fffa, 1'b1, 4'd0, 64'h0000_0000_0000_002a));
        rows.push_back(make_row(32'd0,          32'hffff_ffff, 1'b1, 4'd3, 64'h0000_0000_0000_0000));
        rows.push_back(make_row(32'hffff_ffff, 32'hffff_ffff, 1'b1, 4'd0, 64'h0000_0000_0000_0001));
        rows.push_back(make_row(32'h8000_0000, 32'd1,          1'b1, 4'd4, 64'hffff_ffff_8000_0000));
        rows.push_back(make_row(32'h8000_0000, 32'hffff_ffff, 1'b1, 4'd5, 64'h0000_0000_8000_0000));
        rows.push_back(make_row(32'hffff_ffff, 32'hffff_ffff, 1'b0, 4'd1, 64'hffff_fffe_0000_0001));
        rows.push_back(make_row(32'h8000_0000, 32'd1,          1'b0, 4'd0, 64'h0000_0000_8000_0000));
        rows.push_back(make_row(32'h8000_0000, 32'hffff_ffff, 1'b0, 4'd2, 64'h7fff_ffff_8000_0000));
        rows.push_back(make_row(32'hffff_fffd, 32'd5,          1'b0, 4'd3, 64'h0000_0004_ffff_fff1));

        seed = 32'hebd40026;
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            seed            = lcg_next(seed);
            r.req.op1       = seed;
            seed            = lcg_next(seed);
            r.req.op2       = seed;
            seed            = lcg_next(seed);
            r.req.is_signed = seed[16];
            r.stall         = 4'(seed[23:20] % (MAX_STALL + 1));
            r.expected      = ref_product(r.req);
            rows.push_back(r);
        end
    endtask

    task automatic apply_row(input row_t row);
        int                 waited;
        int                 lat;
        logic [2*WIDTH-1:0] held;
        in_valid = 1'b1;
        in_req   = row.req;
        waited   = 0;
        while (in_ready !== 1'b1 && waited < WIDTH + 4)
        begin
            @(negedge clk);
            waited++;
        end
        if (in_ready !== 1'b1)
        begin
            report_problem("request was never accepted, in_ready stayed low");
            return;
        end
        @(negedge clk); // accept edge has passed
        in_valid = 1'b0;
        in_req   = '0;

        lat = 0;
        while (out_valid !== 1'b1 && lat <= WIDTH + 4)
        begin
            if (in_ready !== 1'b0)
            begin
                report_mismatch("in_ready", 0, in_ready);
            end
            @(negedge clk);
            lat++;
        end
        if (out_valid !== 1'b1)
        begin
            report_problem("out_valid never rose after the request was accepted");
            return;
        end
        if (lat != WIDTH)
        begin
            report_mismatch("latency", WIDTH, lat);
        end

        held = out_rsp.product;
        repeat (row.stall)
        begin
            @(negedge clk);
            if (out_valid !== 1'b1)
            begin
                report_mismatch("out_valid", 1, out_valid);
            end
            if (out_rsp.product !== held)
            begin
                report_mismatch("out_rsp.product", held, out_rsp.product); // moved while stalled
            end
        end
        if (out_rsp.product !== row.expected)
        begin
            report_mismatch("out_rsp.product", row.expected, out_rsp.product);
        end
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        if (out_valid !== 1'b0)
        begin
            report_mismatch("out_valid", 0, out_valid);
        end
        if (in_ready !== 1'b1)
        begin
            report_mismatch("in_ready", 1, in_ready); // ready for the next request
        end
    endtask

    initial
    begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (in_ready !== 1'b1)
        begin
            report_mismatch("in_ready", 1, in_ready);
        end
        if (out_valid !== 1'b0)
        begin
            report_mismatch("out_valid", 0, out_valid);
        end

        build_rows();
        foreach (rows[i])
        begin
            apply_row(rows[i]);
        end

        $display("%0d errors over %0d rows", errors, rows.size());
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/mul_pkg.sv
design/mul_ctrl.sv
design/mul_step_counter.sv
design/mul_shift_add.sv
design/mul_unit.sv
tb/mul_unit_asserts.sv
tb/tb_mul_unit.sv
